// ==== rtl/leg_mode_pkg.sv ====
package leg_mode_pkg;

   // Architectural mode field, ARM CPSR encodings
   typedef enum logic [4:0] {
      mode_usr = 5'b10000,
      mode_fiq = 5'b10001,
      mode_irq = 5'b10010,
      mode_svc = 5'b10011,
      mode_abt = 5'b10111,
      mode_und = 5'b11011,
      mode_sys = 5'b11111
   } mode_e;

   // One-hot mode word
   // Bit order high to low is {user_sys, fiq, irq, svc, abort, undef}
   typedef logic [5:0] mode_onehot_t;

   localparam mode_onehot_t onehot_usr_sys = 6'b100000; // usr and sys share a bank
   localparam mode_onehot_t onehot_fiq     = 6'b010000;
   localparam mode_onehot_t onehot_irq     = 6'b001000;
   localparam mode_onehot_t onehot_svc     = 6'b000100;
   localparam mode_onehot_t onehot_abt     = 6'b000010;
   localparam mode_onehot_t onehot_und     = 6'b000001;

   localparam int fiq_bit = 4; // Position of fiq in the one-hot word

   // Processor comes out of reset in supervisor mode
   localparam mode_e reset_mode = mode_svc;

endpackage

// ==== rtl/leg_regfile_pkg.sv ====
package leg_regfile_pkg;

   // Architectural register number R0..R15
   typedef logic [3:0] arch_reg_t;

   // Physical storage, 16 common plus banked copies plus the Rz shadow
   localparam int num_phys_regs = 32;

   // One bit per physical register
   typedef logic [num_phys_regs-1:0] phys_onehot_t;

   localparam int default_data_width = 32;

   // Fixed register numbers
   localparam arch_reg_t pc_reg_num    = 4'd15;  // R15 / PC
   localparam arch_reg_t sp_reg_num    = 4'd13;  // First banked register of most modes
   localparam arch_reg_t fiq_first_reg = 4'd8;   // FIQ banks R8 upward
   localparam int        rz_phys_index = 31;     // Micro-op shadow register

endpackage

// ==== rtl/regfile_port_if.sv ====
`timescale 1ns/10ps

// One decoded register file access
interface regfile_port_if #(
   parameter int data_width = leg_regfile_pkg::default_data_width
);

   logic                         en;      // Single-cycle strobe
   leg_regfile_pkg::phys_onehot_t sel;    // Decoded physical register
   logic [data_width-1:0]        wdata;   // Write data, unused on read ports
   logic [data_width-1:0]        rdata;   // Read result
   logic                         rvalid;  // One cycle after a read strobe

   // Top level side, drives the request
   modport requester (
      output en,
      output sel,
      output wdata,
      input  rdata,
      input  rvalid
   );

   // Storage side, answers the request
   modport array (
      input  en,
      input  sel,
      input  wdata,
      output rdata,
      output rvalid
   );

endinterface

// ==== rtl/mode_control.sv ====
`timescale 1ns/10ps

module mode_control (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       mode_wr,     // Mode change strobe
   input  leg_mode_pkg::mode_e        mode_in,
   output leg_mode_pkg::mode_e        mode,
   output leg_mode_pkg::mode_onehot_t mode_onehot
);

   logic mode_legal;

   // Only the seven architectural encodings are accepted
   always_comb begin
      case (mode_in)
         leg_mode_pkg::mode_usr,
         leg_mode_pkg::mode_fiq,
         leg_mode_pkg::mode_irq,
         leg_mode_pkg::mode_svc,
         leg_mode_pkg::mode_abt,
         leg_mode_pkg::mode_und,
         leg_mode_pkg::mode_sys: mode_legal = 1'b1;
         default:                mode_legal = 1'b0;  // Reserved code, ignore the write
      endcase
   end

   // Current mode
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mode <= leg_mode_pkg::reset_mode;
      end else if (mode_wr && mode_legal) begin
         mode <= mode_in;  // Decoders see it next cycle
      end
   end

   // Stored mode to one-hot word
   always_comb begin
      case (mode)
         leg_mode_pkg::mode_usr,
         leg_mode_pkg::mode_sys: mode_onehot = leg_mode_pkg::onehot_usr_sys;
         leg_mode_pkg::mode_fiq: mode_onehot = leg_mode_pkg::onehot_fiq;
         leg_mode_pkg::mode_irq: mode_onehot = leg_mode_pkg::onehot_irq;
         leg_mode_pkg::mode_svc: mode_onehot = leg_mode_pkg::onehot_svc;
         leg_mode_pkg::mode_abt: mode_onehot = leg_mode_pkg::onehot_abt;
         leg_mode_pkg::mode_und: mode_onehot = leg_mode_pkg::onehot_und;
         default:                mode_onehot = '0;  // Unreachable, mode is always legal
      endcase
   end

endmodule

// ==== rtl/bank_address_decode.sv ====
`timescale 1ns/10ps

module bank_address_decode (
   input  leg_regfile_pkg::arch_reg_t    reg_num,
   input  logic                          rz_sel,      // Micro-op shadow select
   input  leg_mode_pkg::mode_onehot_t    mode_onehot,
   output leg_regfile_pkg::phys_onehot_t phys_sel
);

   logic [4:0] phys_idx;  // Physical register number
   logic       hit;       // Some register is selected
   logic [4:0] sp_base;   // Physical home of banked R13
   logic       bank_ok;   // Mode word selects a known R13/R14 bank

   // Base of the R13/R14 pair for the current mode
   always_comb begin
      bank_ok = 1'b1;
      case (mode_onehot)
         leg_mode_pkg::onehot_usr_sys: sp_base = 5'd13;
         leg_mode_pkg::onehot_svc:     sp_base = 5'd16;
         leg_mode_pkg::onehot_abt:     sp_base = 5'd18;
         leg_mode_pkg::onehot_und:     sp_base = 5'd20;
         leg_mode_pkg::onehot_irq:     sp_base = 5'd22;
         leg_mode_pkg::onehot_fiq:     sp_base = 5'd29;  // Part of the R8..R14 FIQ bank
         default: begin
            sp_base = 5'd0;
            bank_ok = 1'b0;  // Not one-hot, no bank
         end
      endcase
   end

   always_comb begin
      phys_idx = 5'd0;
      hit      = 1'b0;
      if (rz_sel) begin
         // Rz only reachable through register number 15
         phys_idx = 5'(leg_regfile_pkg::rz_phys_index);
         hit      = (reg_num == leg_regfile_pkg::pc_reg_num);
      end else if (reg_num < leg_regfile_pkg::fiq_first_reg ||
                   reg_num == leg_regfile_pkg::pc_reg_num) begin
         phys_idx = 5'(reg_num);  // R0..R7 and PC are never banked
         hit      = 1'b1;
      end else if (reg_num < leg_regfile_pkg::sp_reg_num) begin
         // R8..R12
         if (!mode_onehot[leg_mode_pkg::fiq_bit]) begin
            phys_idx = 5'(reg_num);
            hit      = 1'b1;
         end else if (mode_onehot == leg_mode_pkg::onehot_fiq) begin
            phys_idx = 5'(reg_num) + 5'd16;  // R8_fiq lives at 24
            hit      = 1'b1;
         end
      end else begin
         // R13 or R14
         phys_idx = sp_base + 5'(reg_num - leg_regfile_pkg::sp_reg_num);
         hit      = bank_ok;
      end
   end

   assign phys_sel = hit ? (leg_regfile_pkg::phys_onehot_t'(1) << phys_idx) : '0;

endmodule

// ==== rtl/banked_register_file.sv ====
`timescale 1ns/10ps

module banked_register_file #(
   parameter int data_width = leg_regfile_pkg::default_data_width
) (
   input  logic           clk,
   input  logic           rst_n,
   regfile_port_if.array  wr,    // Write port, no response
   regfile_port_if.array  rd_a,
   regfile_port_if.array  rd_b
);

   logic [data_width-1:0] regs [leg_regfile_pkg::num_phys_regs];
   logic [data_width-1:0] rd_a_mux;
   logic [data_width-1:0] rd_b_mux;

   // OR of every selected register, zero when nothing selected
   function automatic logic [data_width-1:0] onehot_mux(
      input leg_regfile_pkg::phys_onehot_t sel,
      input logic [data_width-1:0]         r [leg_regfile_pkg::num_phys_regs]
   );
      logic [data_width-1:0] acc;
      acc = '0;
      for (int i = 0; i < leg_regfile_pkg::num_phys_regs; i++) begin
         acc |= r[i] & {data_width{sel[i]}};
      end
      return acc;
   endfunction

   // Storage, all registers clear on reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < leg_regfile_pkg::num_phys_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.en) begin
         for (int i = 0; i < leg_regfile_pkg::num_phys_regs; i++) begin
            if (wr.sel[i]) regs[i] <= wr.wdata;  // Empty select writes nothing
         end
      end
   end

   assign rd_a_mux = onehot_mux(rd_a.sel, regs);  // Sees old value on a same-cycle write
   assign rd_b_mux = onehot_mux(rd_b.sel, regs);

   // Valid flags
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_a.rvalid <= 1'b0;
         rd_b.rvalid <= 1'b0;
      end else begin
         rd_a.rvalid <= rd_a.en;  // One cycle latency
         rd_b.rvalid <= rd_b.en;
      end
   end

   // Read data registers
   always_ff @(posedge clk) begin
      if (rd_a.en) rd_a.rdata <= rd_a_mux;
      if (rd_b.en) rd_b.rdata <= rd_b_mux;
   end

   // Writes get no answer
   assign wr.rdata  = '0;
   assign wr.rvalid = 1'b0;

endmodule

// ==== rtl/regfile_top.sv ====
`timescale 1ns/10ps

module regfile_top #(
   parameter int data_width = leg_regfile_pkg::default_data_width
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       mode_wr,
   input  leg_mode_pkg::mode_e        mode_in,
   output leg_mode_pkg::mode_e        mode,
   input  logic                       wr_en,
   input  leg_regfile_pkg::arch_reg_t wr_reg,
   input  logic                       wr_rz,
   input  logic [data_width-1:0]      wr_data,
   input  logic                       rd_a_en,
   input  leg_regfile_pkg::arch_reg_t rd_a_reg,
   input  logic                       rd_a_rz,
   input  logic                       rd_b_en,
   input  leg_regfile_pkg::arch_reg_t rd_b_reg,
   input  logic                       rd_b_rz,
   output logic [data_width-1:0]      rd_a_data,
   output logic                       rd_a_valid,
   output logic [data_width-1:0]      rd_b_data,
   output logic                       rd_b_valid
);

   leg_mode_pkg::mode_onehot_t mode_onehot;  // Shared by all three decoders

   regfile_port_if #(.data_width(data_width)) wr_if ();
   regfile_port_if #(.data_width(data_width)) rd_a_if ();
   regfile_port_if #(.data_width(data_width)) rd_b_if ();

   mode_control i_mode_control (
      .clk         (clk),
      .rst_n       (rst_n),
      .mode_wr     (mode_wr),
      .mode_in     (mode_in),
      .mode        (mode),
      .mode_onehot (mode_onehot)
   );

   // Write port decode
   bank_address_decode i_wr_decode (
      .reg_num     (wr_reg),
      .rz_sel      (wr_rz),
      .mode_onehot (mode_onehot),
      .phys_sel    (wr_if.sel)
   );

   bank_address_decode i_rd_a_decode (
      .reg_num     (rd_a_reg),
      .rz_sel      (rd_a_rz),
      .mode_onehot (mode_onehot),
      .phys_sel    (rd_a_if.sel)
   );

   bank_address_decode i_rd_b_decode (
      .reg_num     (rd_b_reg),
      .rz_sel      (rd_b_rz),
      .mode_onehot (mode_onehot),
      .phys_sel    (rd_b_if.sel)
   );

   assign wr_if.en      = wr_en;
   assign wr_if.wdata   = wr_data;
   assign rd_a_if.en    = rd_a_en;
   assign rd_a_if.wdata = '0;  // Read ports carry no data in
   assign rd_b_if.en    = rd_b_en;
   assign rd_b_if.wdata = '0;

   banked_register_file #(.data_width(data_width)) i_register_file (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (wr_if.array),
      .rd_a  (rd_a_if.array),
      .rd_b  (rd_b_if.array)
   );

   assign rd_a_data  = rd_a_if.rdata;
   assign rd_a_valid = rd_a_if.rvalid;
   assign rd_b_data  = rd_b_if.rdata;
   assign rd_b_valid = rd_b_if.rvalid;

endmodule

// ==== verif/regfile_properties.sv ====
`timescale 1ns/10ps

module regfile_properties (
   input logic                clk,
   input logic                rst_n,
   input logic                mode_wr,
   input leg_mode_pkg::mode_e mode,
   input logic                rd_a_en,
   input logic                rd_a_valid,
   input logic                rd_b_en,
   input logic                rd_b_valid
);

   // Valid is the strobe delayed by exactly one cycle
   a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
      1'b1 |=> (rd_a_valid == $past(rd_a_en)))
      else $error("rd_a_valid does not follow rd_a_en by one cycle");

   b_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
      1'b1 |=> (rd_b_valid == $past(rd_b_en)))
      else $error("rd_b_valid does not follow rd_b_en by one cycle");

   valid_low_in_reset: assert property (@(posedge clk)
      !rst_n |-> (!rd_a_valid && !rd_b_valid))
      else $error("read valid high during reset");

   // No strobe, no mode change
   mode_held: assert property (@(posedge clk) disable iff (!rst_n)
      !mode_wr |=> $stable(mode))
      else $error("mode changed without mode_wr");

endmodule

bind regfile_top regfile_properties i_properties (
   .clk        (clk),
   .rst_n      (rst_n),
   .mode_wr    (mode_wr),
   .mode       (mode),
   .rd_a_en    (rd_a_en),
   .rd_a_valid (rd_a_valid),
   .rd_b_en    (rd_b_en),
   .rd_b_valid (rd_b_valid)
);

// ==== verif/tb_regfile_top.sv ====
`timescale 1ns/10ps

module tb_regfile_top;

   localparam int data_width     = 32;
   localparam int random_cycles  = 500;
   // Reset, five directed tests, random traffic with its mode changes
   localparam int test_cycles    = 16 + 40 + 30 + 35 + 35 + 20 + random_cycles + 40;
   localparam int timeout_cycles = 2 * test_cycles;

   logic                       clk;
   logic                       rst_n;
   logic                       mode_wr;
   leg_mode_pkg::mode_e        mode_in;
   leg_mode_pkg::mode_e        mode;
   logic                       wr_en;
   leg_regfile_pkg::arch_reg_t wr_reg;
   logic                       wr_rz;
   logic [data_width-1:0]      wr_data;
   logic                       rd_a_en;
   leg_regfile_pkg::arch_reg_t rd_a_reg;
   logic                       rd_a_rz;
   logic                       rd_b_en;
   leg_regfile_pkg::arch_reg_t rd_b_reg;
   logic                       rd_b_rz;
   logic [data_width-1:0]      rd_a_data;
   logic                       rd_a_valid;
   logic [data_width-1:0]      rd_b_data;
   logic                       rd_b_valid;

   logic [data_width-1:0] model_regs [32];  // Expected physical registers
   leg_mode_pkg::mode_e   model_mode;
   logic [data_width-1:0] exp_a [$];        // Results owed on port A
   logic [data_width-1:0] exp_b [$];
   int                    error_count = 0;
   int                    check_count = 0;
   int                    test_count  = 0;
   int                    cycle_count = 0;

   leg_mode_pkg::mode_e all_modes [7] = '{leg_mode_pkg::mode_usr, leg_mode_pkg::mode_fiq,
      leg_mode_pkg::mode_irq, leg_mode_pkg::mode_svc, leg_mode_pkg::mode_abt,
      leg_mode_pkg::mode_und, leg_mode_pkg::mode_sys};
   leg_mode_pkg::mode_e bank_modes [5] = '{leg_mode_pkg::mode_usr, leg_mode_pkg::mode_svc,
      leg_mode_pkg::mode_abt, leg_mode_pkg::mode_und, leg_mode_pkg::mode_irq};

   regfile_top #(.data_width(data_width)) i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 40 ns period
   end

   // Physical index of an access or -1 for an empty decode
   function automatic int ref_phys_index(input leg_mode_pkg::mode_e m, input logic rz,
                                         input leg_regfile_pkg::arch_reg_t r);
      int base;
      if (rz)
         return (r == 4'd15) ? 31 : -1;  // Shadow only via R15
      if (r < 4'd8 || r == 4'd15)
         return int'(r);
      if (m == leg_mode_pkg::mode_fiq)
         return 24 + int'(r) - 8;  // R8..R14 land on 24..30
      if (r < 4'd13)
         return int'(r);
      case (m)
         leg_mode_pkg::mode_svc: base = 16;
         leg_mode_pkg::mode_abt: base = 18;
         leg_mode_pkg::mode_und: base = 20;
         leg_mode_pkg::mode_irq: base = 22;
         default:                base = 13;  // usr and sys share
      endcase
      return base + int'(r) - 13;
   endfunction

   function automatic logic [data_width-1:0] model_read(input int idx);
      if (idx < 0)
         return '0;  // Empty decode reads zero
      return model_regs[idx];
   endfunction

   function automatic bit mode_is_legal(input leg_mode_pkg::mode_e code);
      for (int i = 0; i < 7; i++) begin
         if (code == all_modes[i])
            return 1'b1;
      end
      return 1'b0;
   endfunction

   // Model follows every strobe the DUT samples at this edge
   always @(posedge clk) begin
      int idx;
      if (rst_n) begin
         if (rd_a_en)
            exp_a.push_back(model_read(ref_phys_index(model_mode, rd_a_rz, rd_a_reg)));
         if (rd_b_en)
            exp_b.push_back(model_read(ref_phys_index(model_mode, rd_b_rz, rd_b_reg)));
         idx = ref_phys_index(model_mode, wr_rz, wr_reg);
         if (wr_en && idx >= 0)
            model_regs[idx] = wr_data;  // Updated after the reads so they see old data
         if (mode_wr && mode_is_legal(mode_in))
            model_mode = mode_in;
      end
   end

   task automatic check_read(input string port, input logic valid,
                             input logic [data_width-1:0] data, input bit pending,
                             input logic [data_width-1:0] expected);
      if (valid && !pending) begin
         $display("Port %s gave a valid result at %0t with no read outstanding", port, $time);
         error_count++;
      end else if (!valid && pending) begin
         $display("Port %s read strobe got no valid result at %0t", port, $time);
         error_count++;
      end else if (valid) begin
         check_count++;
         if (data !== expected) begin
            $display("Fail at %0t: port %s read 0x%08h, expected 0x%08h",
                     $time, port, data, expected);
            error_count++;
         end
      end
   endtask

   // Compare process runs mid-cycle where outputs are settled
   always @(negedge clk) begin
      logic [data_width-1:0] expected;
      bit                    pending;
      if (rst_n) begin
         if (mode !== model_mode) begin
            $display("Fail at %0t: mode %s, expected %s", $time, mode.name(), model_mode.name());
            error_count++;
         end
         pending  = (exp_a.size() != 0);
         expected = '0;
         if (pending)
            expected = exp_a.pop_front();
         check_read("A", rd_a_valid, rd_a_data, pending, expected);
         pending  = (exp_b.size() != 0);
         expected = '0;
         if (pending)
            expected = exp_b.pop_front();
         check_read("B", rd_b_valid, rd_b_data, pending, expected);
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
         $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // One clock of stimulus driven 2 ns after the edge
   task automatic drive_cycle(input logic m_wr, input logic [4:0] m_code,
                              input logic w_en, input logic [3:0] w_reg, input logic w_rz,
                              input logic [data_width-1:0] w_data,
                              input logic a_en, input logic [3:0] a_reg, input logic a_rz,
                              input logic b_en, input logic [3:0] b_reg, input logic b_rz);
      @(posedge clk);
      #2;
      mode_wr  = m_wr;
      mode_in  = leg_mode_pkg::mode_e'(m_code);
      wr_en    = w_en;
      wr_reg   = w_reg;
      wr_rz    = w_rz;
      wr_data  = w_data;
      rd_a_en  = a_en;
      rd_a_reg = a_reg;
      rd_a_rz  = a_rz;
      rd_b_en  = b_en;
      rd_b_reg = b_reg;
      rd_b_rz  = b_rz;
   endtask

   task automatic change_mode(input logic [4:0] code);
      drive_cycle(1'b1, code, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
   endtask

   task automatic write_reg(input logic [3:0] r, input logic rz,
                            input logic [data_width-1:0] d);
      drive_cycle('0, '0, 1'b1, r, rz, d, '0, '0, '0, '0, '0, '0);
   endtask

   task automatic read_both(input logic [3:0] a_r, input logic a_z,
                            input logic [3:0] b_r, input logic b_z);
      drive_cycle('0, '0, '0, '0, '0, '0, 1'b1, a_r, a_z, 1'b1, b_r, b_z);
   endtask

   task automatic idle_cycle();
      drive_cycle('0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
   endtask

   // Wait until every read has been answered
   task automatic drain_reads();
      idle_cycle();
      while (exp_a.size() != 0 || exp_b.size() != 0)
         idle_cycle();
   endtask

   task automatic report_test(input string name, input int errors_before);
      test_count++;
      $display("Test %0d %s: %0d errors", test_count, name, error_count - errors_before);
   endtask

   task automatic random_traffic(input int cycles);
      logic [3:0] w_r;
      logic [3:0] a_r;
      logic [3:0] b_r;
      logic [2:0] pick;
      for (int i = 0; i < cycles; i++) begin
         if (i % 32 == 0) begin
            pick = 3'($urandom % 7);
            change_mode(all_modes[pick]);
         end
         w_r = 4'($urandom);
         a_r = ($urandom % 4 == 0) ? w_r : 4'($urandom);  // Frequent read of the written reg
         b_r = 4'($urandom);
         drive_cycle('0, '0, 1'($urandom), w_r, 1'($urandom % 8 == 0), $urandom,
                     1'($urandom), a_r, '0, 1'($urandom), b_r, 1'($urandom % 8 == 0));
      end
   endtask

   initial begin
      int unsigned seed_value;
      int          errors_before;
      logic [4:0]  bad_codes [4];
      seed_value = $urandom(32'h327b_0241);
      bad_codes  = '{5'b00000, 5'b10100, 5'b11110, 5'b01111};  // Reserved mode codes
      rst_n      = 1'b0;
      model_mode = leg_mode_pkg::reset_mode;
      for (int i = 0; i < 32; i++)
         model_regs[i] = '0;
      mode_wr  = 1'b0;
      mode_in  = leg_mode_pkg::mode_svc;
      wr_en    = 1'b0;
      wr_reg   = '0;
      wr_rz    = 1'b0;
      wr_data  = '0;
      rd_a_en  = 1'b0;
      rd_a_reg = '0;
      rd_a_rz  = 1'b0;
      rd_b_en  = 1'b0;
      rd_b_reg = '0;
      rd_b_rz  = 1'b0;
      repeat (16) @(posedge clk);
      #2;
      rst_n = 1'b1;

      errors_before = error_count;
      if (mode !== leg_mode_pkg::mode_svc) begin
         $display("Fail at %0t: mode after reset is %s, expected svc", $time, mode.name());
         error_count++;
      end
      read_both(4'd0, 1'b0, 4'd13, 1'b0);  // Registers come out of reset clear
      change_mode(leg_mode_pkg::mode_sys);
      for (int r = 0; r < 16; r++)
         write_reg(4'(r), 1'b0, $urandom);
      for (int r = 0; r < 16; r++)
         read_both(4'(r), 1'b0, 4'(15 - r), 1'b0);
      drain_reads();
      report_test("reset and system mode", errors_before);

      errors_before = error_count;
      for (int m = 0; m < 5; m++) begin
         change_mode(bank_modes[m]);
         write_reg(4'd13, 1'b0, $urandom);
         write_reg(4'd14, 1'b0, $urandom);
      end
      for (int m = 0; m < 5; m++) begin
         change_mode(bank_modes[m]);
         read_both(4'd13, 1'b0, 4'd14, 1'b0);
      end
      drain_reads();
      report_test("R13/R14 banking", errors_before);

      errors_before = error_count;
      change_mode(leg_mode_pkg::mode_usr);
      for (int r = 8; r < 15; r++)
         write_reg(4'(r), 1'b0, $urandom);
      change_mode(leg_mode_pkg::mode_fiq);
      for (int r = 8; r < 15; r++)
         write_reg(4'(r), 1'b0, $urandom);
      change_mode(leg_mode_pkg::mode_sys);  // Must see the user bank
      for (int r = 8; r < 15; r++)
         read_both(4'(r), 1'b0, 4'(r), 1'b0);
      change_mode(leg_mode_pkg::mode_fiq);
      for (int r = 8; r < 15; r++)
         read_both(4'(r), 1'b0, 4'(r), 1'b0);
      drain_reads();
      report_test("FIQ banking", errors_before);

      errors_before = error_count;
      for (int m = 0; m < 7; m++) begin
         change_mode(all_modes[m]);
         write_reg(4'd15, 1'b1, $urandom);
         write_reg(4'd15, 1'b0, $urandom);
         read_both(4'd15, 1'b1, 4'd15, 1'b0);
      end
      drain_reads();
      report_test("shadow register", errors_before);

      errors_before = error_count;
      change_mode(leg_mode_pkg::mode_usr);
      write_reg(4'd13, 1'b0, $urandom);
      for (int i = 0; i < 4; i++) begin
         change_mode(bad_codes[i]);
         idle_cycle();
         if (mode !== leg_mode_pkg::mode_usr) begin
            $display("Fail at %0t: mode %s after code %b, expected usr",
                     $time, mode.name(), bad_codes[i]);
            error_count++;
         end
         read_both(4'd13, 1'b0, 4'd8, 1'b0);
      end
      drain_reads();
      report_test("illegal mode codes", errors_before);

      errors_before = error_count;
      random_traffic(random_cycles);
      drain_reads();
      report_test("random back-to-back traffic", errors_before);

      $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
      if (error_count == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== sources.f ====
rtl/leg_mode_pkg.sv
rtl/leg_regfile_pkg.sv
rtl/regfile_port_if.sv
rtl/mode_control.sv
rtl/bank_address_decode.sv
rtl/banked_register_file.sv
rtl/regfile_top.sv
verif/regfile_properties.sv
verif/tb_regfile_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_regfile_top \
   && ./obj_dir/Vtb_regfile_top > sim.log 2>&1 \
   || echo "Build or simulation stopped early" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && echo "Result: FAIL" && exit 1
grep -q "ALL TESTS PASSED" sim.log && echo "Result: PASS" && exit 0
echo "Result: FAIL, no result line in sim.log" && exit 1
